// File: coh_dir_ctrl.f
hdl/coh_dir_pkg.sv
hdl/coh_req_if.sv
hdl/coh_res_if.sv
hdl/coh_req_decode.sv
hdl/coh_mesi_transition.sv
hdl/coh_result_stage.sv
hdl/coh_dir_ctrl.sv
tb/coh_dir_ctrl_tb.sv

// File: Bender.yml
package:
  name: coh_dir_ctrl

sources:
  - files:
      - hdl/coh_dir_pkg.sv
      - hdl/coh_req_if.sv
      - hdl/coh_res_if.sv
      - hdl/coh_req_decode.sv
      - hdl/coh_mesi_transition.sv
      - hdl/coh_result_stage.sv
      - hdl/coh_dir_ctrl.sv
  - target: test
    files:
      - tb/coh_dir_ctrl_tb.sv

// File: tb/coh_dir_ctrl_tb.sv
/*
 * Testbench for the MESI directory controller
 * Directed and random requests, scoreboard of expected responses and snoops
 */
`timescale 1ns/1ps
`default_nettype none

module coh_dir_ctrl_tb;
    import coh_dir_pkg::*;

    localparam time CLK_PERIOD   = 100ns;
    localparam int  NUM_DIRECTED = 24;
    localparam int  NUM_RANDOM   = 200;
    localparam int  NUM_BURST    = 32;
    localparam int  WATCHDOG_CYC = (NUM_DIRECTED + NUM_RANDOM + NUM_BURST) * 40;
    localparam logic [31:0] SEED = 32'h6ae598be;

    typedef struct packed {
        logic [ADDR_W-1:0]      addr;
        dir_entry_t             entry;
        coh_action_t            act;
        logic                   chg;
        coh_err_e               err;
        logic                   snp;
        snp_opcode_e            op;
        logic [NUM_NODES-1:0]   tgt;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    logic [ADDR_W-1:0]      req_addr;
    coh_event_e             req_event;
    logic [NODE_ID_W-1:0]   req_node_id;
    dir_entry_t             cur_entry;
    logic                   rsp_valid;
    logic                   rsp_ready;
    dir_entry_t             rsp_entry;
    coh_action_t            rsp_actions;
    logic                   rsp_changed;
    logic                   rsp_error;
    coh_err_e               rsp_err_code;
    logic                   snoop_valid;
    logic                   snoop_ready;
    logic [ADDR_W-1:0]      snoop_addr;
    snp_opcode_e            snoop_opcode;
    logic [NUM_NODES-1:0]   snoop_targets;

    expect_t    rsp_q[$];
    expect_t    snp_q[$];
    longint     acc_cyc_q[$];
    longint     cycle = 0;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         test_err_base = 0;
    int         max_inflight = 0;
    logic       stall_en = 1'b0;
    logic       burst_mode = 1'b0;
    logic [31:0] stim_lfsr = SEED;
    logic [31:0] stall_lfsr = SEED;
    logic [ADDR_W-1:0] next_addr = 48'h0000_1000_0000;

    coh_dir_ctrl coh_dir_ctrl_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    // ========================================
    // Reference MESI rules
    // ========================================
    function automatic expect_t predict(input dir_entry_t e, input coh_event_e ev,
                                        input logic [NODE_ID_W-1:0] node);
        expect_t x;
        logic [NUM_NODES-1:0] oh;
        logic [NUM_NODES-1:0] others;
        logic own;
        logic m;
        logic rd;
        logic wr;
        logic up;
        logic evc;
        logic wb;
        oh     = NUM_NODES'(1) << node;
        others = e.sharer_mask & ~oh;
        own    = (node == e.owner_id);
        m      = (e.state == DIR_MODIFIED);
        rd     = (ev == EVENT_CPU_READ) || (ev == EVENT_READ_REQ);
        wr     = (ev == EVENT_CPU_WRITE) || (ev == EVENT_WRITE_REQ);
        up     = (ev == EVENT_UPGRADE_REQ);
        evc    = (ev == EVENT_CPU_EVICT);
        wb     = (ev == EVENT_WRITEBACK);
        x       = '0;
        x.entry = e;
        x.err   = ERR_NONE;
        x.op    = SNP_SHARED;
        if (e.state == DIR_INVALID) begin
            if (rd || wr) begin
                x.entry = '{rd ? DIR_EXCLUSIVE : DIR_MODIFIED, wr, node, oh};
                x.act.mem_read = 1'b1;
                x.act.cpu_data = 1'b1;
                x.act.update_directory = 1'b1;
            end else x.err = ERR_FROM_I;
        end else if (e.state == DIR_SHARED) begin
            if (rd) begin
                x.entry.sharer_mask = e.sharer_mask | oh;
                x.act.cpu_data = 1'b1;
                x.act.update_directory = 1'b1;
            end else if (wr || up) begin
                x.entry = '{DIR_MODIFIED, 1'b1, node, oh};
                x.act.snoop_invalidate = 1'b1;
                x.act.cpu_ack = 1'b1;
                x.act.update_directory = 1'b1;
                x.snp = (others != '0);
                x.op  = SNP_MAKE_INVALID;
                x.tgt = x.snp ? others : '0;
            end else if (evc) begin
                x.entry.sharer_mask = others;
                if (others == '0) x.entry.state = DIR_INVALID;
                x.act.cpu_ack = 1'b1;
                x.act.update_directory = 1'b1;
            end else x.err = ERR_FROM_S;
        end else begin
            if (rd && own) begin
                x.act.cpu_data = 1'b1;
            end else if (rd) begin
                x.entry.state = DIR_SHARED;
                x.entry.dirty = 1'b0;
                x.entry.sharer_mask = e.sharer_mask | oh;
                x.act.snoop_shared = 1'b1;
                x.act.cpu_data = 1'b1;
                x.act.update_directory = 1'b1;
                x.act.mem_write = m;
                x.snp = 1'b1;
                x.tgt = NUM_NODES'(1) << e.owner_id;
            end else if (wr && own) begin
                x.act.cpu_ack = 1'b1;
                if (!m) begin
                    x.entry.state = DIR_MODIFIED;
                    x.entry.dirty = 1'b1;
                    x.act.update_directory = 1'b1;
                end
            end else if (wr) begin
                x.entry = '{DIR_MODIFIED, 1'b1, node, oh};
                x.act.snoop_invalidate = 1'b1;
                x.act.cpu_data = 1'b1;
                x.act.update_directory = 1'b1;
                x.snp = 1'b1;
                x.op  = SNP_MAKE_INVALID;
                x.tgt = NUM_NODES'(1) << e.owner_id;
            end else if (evc && !m) begin
                if (own) begin
                    x.entry = '0;
                    x.act.cpu_ack = 1'b1;
                    x.act.update_directory = 1'b1;
                end else x.err = ERR_EVICT_NON_OWNER;
            end else if (wb && m) begin
                if (own) begin
                    x.entry = '0;
                    x.act.mem_write = 1'b1;
                    x.act.cpu_ack = 1'b1;
                    x.act.update_directory = 1'b1;
                end else x.err = ERR_WB_NON_OWNER;
            end else x.err = m ? ERR_FROM_M : ERR_FROM_E;
        end
        x.chg = (x.entry != e);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h at cycle %0d", name, got, exp, cycle);
            errors++;
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok) else begin
            $display("%s at cycle %0d", what, cycle);
            errors++;
        end
    endtask

    // ========================================
    // Scoreboard
    // ========================================
    always @(posedge clk) begin
        expect_t x;
        longint  t0;
        if (rst_n) begin
            cycle++;
            if (rsp_q.size() > max_inflight) max_inflight = rsp_q.size();
            check_cond(rsp_q.size() <= 2, "More than two requests held in flight");
            if (rsp_valid && rsp_ready) begin
                if (rsp_q.size() == 0) begin
                    check_cond(1'b0, "Response seen with no request outstanding");
                end else begin
                    x  = rsp_q.pop_front();
                    t0 = acc_cyc_q.pop_front();
                    check_val("rsp_entry", rsp_entry, x.entry);
                    check_val("rsp_actions", rsp_actions, x.act);
                    check_val("rsp_changed", rsp_changed, x.chg);
                    check_val("rsp_err_code", rsp_err_code, x.err);
                    check_val("rsp_error", rsp_error, x.err != ERR_NONE);
                    check_cond(cycle - t0 >= 2, "Response came sooner than two cycles");
                end
            end
            if (snoop_valid && snoop_ready) begin
                if (snp_q.size() == 0) begin
                    check_cond(1'b0, "Snoop issued where none was expected");
                end else begin
                    x = snp_q.pop_front();
                    check_val("snoop_addr", snoop_addr, x.addr);
                    check_val("snoop_opcode", snoop_opcode, x.op);
                    check_val("snoop_targets", snoop_targets, x.tgt);
                end
            end
            if (req_valid && req_ready) begin
                x = predict(cur_entry, req_event, req_node_id);
                x.addr = req_addr;
                rsp_q.push_back(x);
                acc_cyc_q.push_back(cycle);
                if (x.snp) snp_q.push_back(x);
            end
        end
    end

    // Back-pressure on both output channels
    always @(negedge clk) begin
        if (stall_en) begin
            stall_lfsr  = lfsr_step(stall_lfsr);
            rsp_ready   = stall_lfsr[0];
            stall_lfsr  = lfsr_step(stall_lfsr);
            snoop_ready = stall_lfsr[0];
        end else begin
            rsp_ready   = 1'b1;
            snoop_ready = 1'b1;
        end
    end

    // Starts and ends on a falling edge
    task automatic send(input coh_event_e ev, input logic [NODE_ID_W-1:0] node,
                        input dir_entry_t e);
        int waits;
        waits       = 0;
        req_valid   = 1'b1;
        req_event   = ev;
        req_node_id = node;
        cur_entry   = e;
        req_addr    = next_addr;
        next_addr   = next_addr + 48'h40;
        do begin
            @(posedge clk);
            waits++;
        end while (!req_ready);
        if (burst_mode) check_cond(waits == 1, "Request stalled during unstalled burst");
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (rsp_q.size() != 0 || snp_q.size() != 0 || rsp_valid || snoop_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - test_err_base;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("Test %-12s %s (%0d errors)", name, (n == 0) ? "PASS" : "FAIL", n);
        test_err_base = errors;
    endtask

    function automatic dir_entry_t mk(input dir_state_e s, input logic d,
                                      input logic [3:0] own, input logic [15:0] mask);
        return '{s, d, own, mask};
    endfunction

    task automatic send_random();
        logic [31:0] r;
        dir_entry_t  e;
        logic [3:0]  node;
        coh_event_e  ev;
        rand_bits(4, r);
        ev = coh_event_e'(r % 14);
        rand_bits(4, r);
        node = r[3:0];
        rand_bits(23, r);
        e = r[22:0];
        send(ev, node, e);
    endtask

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_event   = EVENT_CPU_READ;
        req_node_id = '0;
        cur_entry   = '0;
        rsp_ready   = 1'b1;
        snoop_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_val("req_ready", req_ready, 1);
        check_val("rsp_valid", rsp_valid, 0);
        check_val("snoop_valid", snoop_valid, 0);
        finish_test("reset");

        // Legal transitions from each state
        send(EVENT_CPU_READ, 4'd3, mk(DIR_INVALID, 0, 0, 0));
        send(EVENT_WRITE_REQ, 4'd5, mk(DIR_INVALID, 0, 0, 0));
        send(EVENT_READ_REQ, 4'd2, mk(DIR_SHARED, 0, 1, 16'h0002));
        send(EVENT_CPU_EVICT, 4'd1, mk(DIR_SHARED, 0, 1, 16'h0006));
        send(EVENT_CPU_EVICT, 4'd1, mk(DIR_SHARED, 0, 1, 16'h0002));
        send(EVENT_CPU_READ, 4'd7, mk(DIR_EXCLUSIVE, 0, 7, 16'h0080));
        send(EVENT_CPU_WRITE, 4'd7, mk(DIR_EXCLUSIVE, 0, 7, 16'h0080));
        send(EVENT_CPU_EVICT, 4'd7, mk(DIR_EXCLUSIVE, 0, 7, 16'h0080));
        send(EVENT_CPU_WRITE, 4'd9, mk(DIR_MODIFIED, 1, 9, 16'h0200));
        send(EVENT_WRITEBACK, 4'd9, mk(DIR_MODIFIED, 1, 9, 16'h0200));
        drain();
        finish_test("directed");

        // Snoop generation
        send(EVENT_UPGRADE_REQ, 4'd0, mk(DIR_SHARED, 0, 0, 16'h8011));
        send(EVENT_CPU_WRITE, 4'd4, mk(DIR_SHARED, 0, 4, 16'h0010));
        send(EVENT_UPGRADE_REQ, 4'd4, mk(DIR_SHARED, 0, 4, 16'h0010));
        send(EVENT_READ_REQ, 4'd2, mk(DIR_EXCLUSIVE, 0, 12, 16'h1000));
        send(EVENT_CPU_READ, 4'd6, mk(DIR_MODIFIED, 1, 15, 16'h8000));
        send(EVENT_WRITE_REQ, 4'd1, mk(DIR_EXCLUSIVE, 0, 8, 16'h0100));
        send(EVENT_CPU_WRITE, 4'd3, mk(DIR_MODIFIED, 1, 10, 16'h0400));
        drain();
        finish_test("snoop");

        // Illegal events and non-owner evict or writeback
        send(EVENT_CPU_EVICT, 4'd1, mk(DIR_INVALID, 0, 0, 0));
        send(EVENT_MEM_DATA, 4'd1, mk(DIR_SHARED, 0, 1, 16'h0002));
        send(EVENT_CPU_EVICT, 4'd2, mk(DIR_EXCLUSIVE, 0, 5, 16'h0020));
        send(EVENT_WRITEBACK, 4'd5, mk(DIR_EXCLUSIVE, 0, 5, 16'h0020));
        send(EVENT_WRITEBACK, 4'd2, mk(DIR_MODIFIED, 1, 5, 16'h0020));
        send(EVENT_UPGRADE_REQ, 4'd5, mk(DIR_MODIFIED, 1, 5, 16'h0020));
        send(EVENT_SNOOP_MISS, 4'd0, mk(DIR_INVALID, 0, 0, 0));
        drain();
        finish_test("errors");

        stall_en = 1'b1;
        repeat (NUM_RANDOM) send_random();
        drain();
        stall_en = 1'b0;
        @(negedge clk);
        finish_test("random");

        max_inflight = 0;
        burst_mode   = 1'b1;
        repeat (NUM_BURST) send_random();
        burst_mode = 1'b0;
        drain();
        check_val("max_inflight", max_inflight, 2);
        finish_test("burst");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * WATCHDOG_CYC);
        $display("Timeout after %0d cycles, the run did not complete", WATCHDOG_CYC);
        $display("Test failures found");
        $finish;
    end

endmodule : coh_dir_ctrl_tb

`default_nettype wire

// File: hdl/coh_dir_ctrl.sv
/*
 * MESI directory controller, 16 nodes
 * Decode, transition and output stages, two requests in flight
 */
`timescale 1ns/1ps
`default_nettype none

module coh_dir_ctrl (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Request
    input  wire logic                               req_valid,
    output logic                                    req_ready,
    input  wire logic [coh_dir_pkg::ADDR_W-1:0]     req_addr,
    input  coh_dir_pkg::coh_event_e                 req_event,
    input  wire logic [coh_dir_pkg::NODE_ID_W-1:0]  req_node_id,
    input  coh_dir_pkg::dir_entry_t                 cur_entry,

    // Response
    output logic                                    rsp_valid,
    input  wire logic                               rsp_ready,
    output coh_dir_pkg::dir_entry_t                 rsp_entry,
    output coh_dir_pkg::coh_action_t                rsp_actions,
    output logic                                    rsp_changed,
    output logic                                    rsp_error,
    output coh_dir_pkg::coh_err_e                   rsp_err_code,

    // Snoop
    output logic                                    snoop_valid,
    input  wire logic                               snoop_ready,
    output logic [coh_dir_pkg::ADDR_W-1:0]          snoop_addr,
    output coh_dir_pkg::snp_opcode_e                snoop_opcode,
    output logic [coh_dir_pkg::NUM_NODES-1:0]       snoop_targets
);

    coh_req_if req_ch ();
    coh_res_if res_ch ();

    coh_req_decode coh_req_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_addr    (req_addr),
        .req_event   (req_event),
        .req_node_id (req_node_id),
        .cur_entry   (cur_entry),
        .req         (req_ch.decode)
    );

    coh_mesi_transition coh_mesi_transition_i (
        .req (req_ch.execute),
        .res (res_ch.execute)
    );

    coh_result_stage coh_result_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .res           (res_ch.result),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_entry     (rsp_entry),
        .rsp_actions   (rsp_actions),
        .rsp_changed   (rsp_changed),
        .rsp_error     (rsp_error),
        .rsp_err_code  (rsp_err_code),
        .snoop_valid   (snoop_valid),
        .snoop_ready   (snoop_ready),
        .snoop_addr    (snoop_addr),
        .snoop_opcode  (snoop_opcode),
        .snoop_targets (snoop_targets)
    );

endmodule : coh_dir_ctrl

`default_nettype wire

// File: hdl/coh_result_stage.sv
/*
 * Result and snoop output stage
 * Holds one result, response and snoop handshake independently
 */
`timescale 1ns/1ps
`default_nettype none

module coh_result_stage (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    coh_res_if.result                               res,
    output logic                                    rsp_valid,
    input  wire logic                               rsp_ready,
    output coh_dir_pkg::dir_entry_t                 rsp_entry,
    output coh_dir_pkg::coh_action_t                rsp_actions,
    output logic                                    rsp_changed,
    output logic                                    rsp_error,
    output coh_dir_pkg::coh_err_e                   rsp_err_code,
    output logic                                    snoop_valid,
    input  wire logic                               snoop_ready,
    output logic [coh_dir_pkg::ADDR_W-1:0]          snoop_addr,
    output coh_dir_pkg::snp_opcode_e                snoop_opcode,
    output logic [coh_dir_pkg::NUM_NODES-1:0]       snoop_targets
);
    import coh_dir_pkg::*;

    logic rsp_pend;
    logic snp_pend;
    logic load;

    // Both channels done or never pending, so the slot frees this cycle
    assign res.ready = (!rsp_pend || rsp_ready) && (!snp_pend || snoop_ready);
    assign load      = res.valid && res.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_pend <= 1'b0;
            snp_pend <= 1'b0;
        end else if (load) begin
            rsp_pend <= 1'b1;
            snp_pend <= res.snoop_req;
        end else begin
            if (rsp_ready) begin
                rsp_pend <= 1'b0;
            end
            if (snoop_ready) begin
                snp_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp_entry     <= res.new_entry;
            rsp_actions   <= res.actions;
            rsp_changed   <= res.changed;
            rsp_err_code  <= res.err_code;
            snoop_addr    <= res.addr;
            snoop_opcode  <= res.snoop_opcode;
            snoop_targets <= res.snoop_targets;
        end
    end

    assign rsp_valid   = rsp_pend;
    assign snoop_valid = snp_pend;
    assign rsp_error   = (rsp_err_code != ERR_NONE);

endmodule : coh_result_stage

`default_nettype wire

// File: hdl/coh_mesi_transition.sv
/*
 * MESI transition block
 * Combinational next entry, actions, snoop and error code for one request
 */
`timescale 1ns/1ps
`default_nettype none

module coh_mesi_transition (
    coh_req_if.execute req,
    coh_res_if.execute res
);
    import coh_dir_pkg::*;

    dir_entry_t             nxt;
    coh_action_t            act;
    coh_err_e               err;
    logic                   snp_req;
    snp_opcode_e            snp_op;
    logic [NUM_NODES-1:0]   snp_tgt;
    logic [NUM_NODES-1:0]   owner_onehot;
    logic [NUM_NODES-1:0]   others;
    logic                   is_m;

    // Requester takes the line modified and alone
    function automatic dir_entry_t take_modified(logic [NODE_ID_W-1:0] node,
                                                 logic [NUM_NODES-1:0] onehot);
        dir_entry_t e;
        e.state       = DIR_MODIFIED;
        e.dirty       = 1'b1;
        e.owner_id    = node;
        e.sharer_mask = onehot;
        return e;
    endfunction

    assign owner_onehot = NUM_NODES'(1) << req.entry.owner_id;
    assign others       = req.entry.sharer_mask & ~req.req_onehot;
    assign is_m         = (req.entry.state == DIR_MODIFIED);

    // ========================================
    // Transition rules
    // ========================================
    always_comb begin
        nxt     = req.entry;
        act     = '0;
        err     = ERR_NONE;
        snp_req = 1'b0;
        snp_op  = SNP_SHARED;
        snp_tgt = '0;

        case (req.entry.state)
            DIR_INVALID: begin
                if (req.evt_class == EVT_READ || req.evt_class == EVT_WRITE) begin
                    nxt = take_modified(req.node_id, req.req_onehot);
                    if (req.evt_class == EVT_READ) begin
                        nxt.state = DIR_EXCLUSIVE;
                        nxt.dirty = 1'b0;
                    end
                    act.mem_read         = 1'b1;
                    act.cpu_data         = 1'b1;
                    act.update_directory = 1'b1;
                end else begin
                    err = ERR_FROM_I;
                end
            end

            DIR_SHARED: begin
                case (req.evt_class)
                    EVT_READ: begin
                        nxt.sharer_mask      = req.entry.sharer_mask | req.req_onehot;
                        act.cpu_data         = 1'b1;
                        act.update_directory = 1'b1;
                    end
                    EVT_WRITE, EVT_UPGRADE: begin
                        nxt = take_modified(req.node_id, req.req_onehot);
                        act.snoop_invalidate = 1'b1;
                        act.cpu_ack          = 1'b1;
                        act.update_directory = 1'b1;
                        // Only other sharers need invalidating
                        snp_req = |others;
                        snp_op  = SNP_MAKE_INVALID;
                        snp_tgt = others;
                    end
                    EVT_EVICT: begin
                        nxt.sharer_mask = others;
                        if (others == '0) begin
                            nxt.state = DIR_INVALID;
                        end
                        act.cpu_ack          = 1'b1;
                        act.update_directory = 1'b1;
                    end
                    default: err = ERR_FROM_S;
                endcase
            end

            // Exclusive and modified share most rules
            default: begin
                case (req.evt_class)
                    EVT_READ: begin
                        act.cpu_data = 1'b1;
                        if (!req.is_owner) begin
                            nxt.state            = DIR_SHARED;
                            nxt.dirty            = 1'b0;
                            nxt.sharer_mask      = req.entry.sharer_mask | req.req_onehot;
                            act.snoop_shared     = 1'b1;
                            act.mem_write        = is_m;
                            act.update_directory = 1'b1;
                            snp_req = 1'b1;
                            snp_op  = SNP_SHARED;
                            snp_tgt = owner_onehot;
                        end
                    end
                    EVT_WRITE: begin
                        if (req.is_owner) begin
                            act.cpu_ack = 1'b1;
                            if (!is_m) begin
                                nxt.state            = DIR_MODIFIED;
                                nxt.dirty            = 1'b1;
                                act.update_directory = 1'b1;
                            end
                        end else begin
                            nxt = take_modified(req.node_id, req.req_onehot);
                            act.snoop_invalidate = 1'b1;
                            act.cpu_data         = 1'b1;
                            act.update_directory = 1'b1;
                            snp_req = 1'b1;
                            snp_op  = SNP_MAKE_INVALID;
                            snp_tgt = owner_onehot;
                        end
                    end
                    EVT_EVICT: begin
                        if (is_m) begin
                            err = ERR_FROM_M;
                        end else if (!req.is_owner) begin
                            err = ERR_EVICT_NON_OWNER;
                        end else begin
                            nxt                  = '0;
                            act.cpu_ack          = 1'b1;
                            act.update_directory = 1'b1;
                        end
                    end
                    EVT_WRITEBACK: begin
                        if (!is_m) begin
                            err = ERR_FROM_E;
                        end else if (!req.is_owner) begin
                            err = ERR_WB_NON_OWNER;
                        end else begin
                            nxt                  = '0;
                            act.mem_write        = 1'b1;
                            act.cpu_ack          = 1'b1;
                            act.update_directory = 1'b1;
                        end
                    end
                    default: err = is_m ? ERR_FROM_M : ERR_FROM_E;
                endcase
            end
        endcase
    end

    // ========================================
    // Result channel
    // ========================================
    assign res.valid         = req.valid;
    assign req.ready         = res.ready;
    assign res.addr          = req.addr;
    assign res.new_entry     = nxt;
    assign res.actions       = act;
    assign res.changed       = (nxt != req.entry);
    assign res.snoop_req     = snp_req;
    assign res.snoop_opcode  = snp_op;
    assign res.snoop_targets = snp_tgt;
    assign res.err_code      = err;

endmodule : coh_mesi_transition

`default_nettype wire

// File: hdl/coh_req_decode.sv
/*
 * Request decoder
 * Registers one request and classifies its event and requester
 */
`timescale 1ns/1ps
`default_nettype none

module coh_req_decode (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           req_valid,
    output logic                                req_ready,
    input  wire logic [coh_dir_pkg::ADDR_W-1:0] req_addr,
    input  coh_dir_pkg::coh_event_e             req_event,
    input  wire logic [coh_dir_pkg::NODE_ID_W-1:0] req_node_id,
    input  coh_dir_pkg::dir_entry_t             cur_entry,
    coh_req_if.decode                           req
);
    import coh_dir_pkg::*;

    function automatic evt_class_e classify(coh_event_e ev);
        case (ev)
            EVENT_CPU_READ, EVENT_READ_REQ:   return EVT_READ;
            EVENT_CPU_WRITE, EVENT_WRITE_REQ: return EVT_WRITE;
            EVENT_UPGRADE_REQ:                return EVT_UPGRADE;
            EVENT_CPU_EVICT:                  return EVT_EVICT;
            EVENT_WRITEBACK:                  return EVT_WRITEBACK;
            default:                          return EVT_OTHER;
        endcase
    endfunction

    // Free slot, or the held request leaves this cycle
    assign req_ready = !req.valid || req.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (req_ready) begin
            req.valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req.addr       <= req_addr;
            req.node_id    <= req_node_id;
            req.entry      <= cur_entry;
            req.evt_class  <= classify(req_event);
            req.is_owner   <= (req_node_id == cur_entry.owner_id);
            req.req_onehot <= NUM_NODES'(1) << req_node_id;
        end
    end

endmodule : coh_req_decode

`default_nettype wire

// File: hdl/coh_res_if.sv
/*
 * Computed result channel, MESI transition block to output stage
 */
`timescale 1ns/1ps
`default_nettype none

interface coh_res_if;
    import coh_dir_pkg::*;

    logic                   valid;
    logic                   ready;
    logic [ADDR_W-1:0]      addr;
    dir_entry_t             new_entry;
    coh_action_t            actions;
    logic                   changed;
    logic                   snoop_req;
    snp_opcode_e            snoop_opcode;
    logic [NUM_NODES-1:0]   snoop_targets;
    coh_err_e               err_code;

    modport execute (
        output valid, addr, new_entry, actions, changed,
               snoop_req, snoop_opcode, snoop_targets, err_code,
        input  ready
    );

    modport result (
        input  valid, addr, new_entry, actions, changed,
               snoop_req, snoop_opcode, snoop_targets, err_code,
        output ready
    );

endinterface : coh_res_if

`default_nettype wire

// File: hdl/coh_req_if.sv
/*
 * Decoded request channel, decoder to MESI transition block
 */
`timescale 1ns/1ps
`default_nettype none

interface coh_req_if;
    import coh_dir_pkg::*;

    logic                   valid;
    logic                   ready;
    logic [ADDR_W-1:0]      addr;
    logic [NODE_ID_W-1:0]   node_id;
    logic [NUM_NODES-1:0]   req_onehot;
    dir_entry_t             entry;
    evt_class_e             evt_class;
    logic                   is_owner;

    modport decode (
        output valid, addr, node_id, req_onehot, entry, evt_class, is_owner,
        input  ready
    );

    modport execute (
        input  valid, addr, node_id, req_onehot, entry, evt_class, is_owner,
        output ready
    );

endinterface : coh_req_if

`default_nettype wire

// File: hdl/coh_dir_pkg.sv
/*
 * MESI directory controller package
 * Sizes, event and state encodings, directory entry and action types
 */
`default_nettype none

package coh_dir_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int NUM_NODES = 16;
    localparam int NODE_ID_W = 4;
    localparam int ADDR_W    = 48;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [1:0] {
        DIR_INVALID   = 2'd0,
        DIR_SHARED    = 2'd1,
        DIR_EXCLUSIVE = 2'd2,
        DIR_MODIFIED  = 2'd3
    } dir_state_e;

    typedef enum logic [3:0] {
        EVENT_CPU_READ    = 4'h0,
        EVENT_CPU_WRITE   = 4'h1,
        EVENT_CPU_EVICT   = 4'h2,
        EVENT_READ_REQ    = 4'h3,
        EVENT_WRITE_REQ   = 4'h4,
        EVENT_UPGRADE_REQ = 4'h5,
        // Snoop and memory responses, accepted but only ever errors here
        EVENT_SNOOP_HIT_M = 4'h6,
        EVENT_SNOOP_HIT_E = 4'h7,
        EVENT_SNOOP_HIT_S = 4'h8,
        EVENT_SNOOP_MISS  = 4'h9,
        EVENT_MEM_DATA    = 4'hA,
        EVENT_MEM_ACK     = 4'hB,
        EVENT_INVALIDATE  = 4'hC,
        EVENT_WRITEBACK   = 4'hD
    } coh_event_e;

    typedef enum logic [2:0] {
        EVT_READ,
        EVT_WRITE,
        EVT_UPGRADE,
        EVT_EVICT,
        EVT_WRITEBACK,
        EVT_OTHER
    } evt_class_e;

    typedef enum logic {
        SNP_SHARED       = 1'b0,
        SNP_MAKE_INVALID = 1'b1
    } snp_opcode_e;

    typedef enum logic [7:0] {
        ERR_NONE            = 8'h00,
        ERR_FROM_I          = 8'h01,
        ERR_FROM_S          = 8'h02,
        ERR_EVICT_NON_OWNER = 8'h03,
        ERR_FROM_E          = 8'h04,
        ERR_WB_NON_OWNER    = 8'h05,
        ERR_FROM_M          = 8'h06
    } coh_err_e;

    // ========================================
    // Directory entry and action flags
    // ========================================
    typedef struct packed {
        dir_state_e             state;
        logic                   dirty;
        logic [NODE_ID_W-1:0]   owner_id;
        logic [NUM_NODES-1:0]   sharer_mask;
    } dir_entry_t;

    typedef struct packed {
        logic snoop_shared;
        logic snoop_exclusive;
        logic snoop_invalidate;
        logic mem_read;
        logic mem_write;
        logic cpu_data;
        logic cpu_ack;
        logic net_data;
        logic net_ack;
        logic update_directory;
    } coh_action_t;

endpackage : coh_dir_pkg

`default_nettype wire
